// ==== all.f ====
hw/filt_cfg_pkg.sv
hw/filt_bus_pkg.sv
hw/filt_ctrl.sv
hw/sym_delay_line.sv
hw/level_mapper.sv
hw/product_lut.sv
hw/adder_tree.sv
hw/pam_fir_top.sv
testbench/pam_fir_sva.sv
testbench/pam_fir_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= pam_fir_tb
FILELIST  ?= all.f
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "result: FAIL, run incomplete"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/pam_fir_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam_fir_tb;

    localparam int clk_half = 4;
    localparam int reset_cycles = 5;
    localparam int stream_half = 100;
    localparam int max_gap = 3;
    // two apb cycles per table entry
    localparam int load_cycles = 2 * filt_cfg_pkg::num_uniq * filt_cfg_pkg::num_levels;
    localparam int test_cycles = reset_cycles + 40 + (load_cycles + 60)
        + (load_cycles + stream_half * (2 + max_gap) + 40) + 100 + 120 + 80;
    localparam int timeout_cycles = 2 * test_cycles;
    localparam int sample_hi = 131071;
    localparam int sample_lo = -131072;

    logic sys_clk = 1'b0;
    logic reset;
    filt_bus_pkg::apb_req_t apb_req;
    filt_bus_pkg::apb_rsp_t apb_rsp;
    logic sample_en;
    filt_cfg_pkg::sample_t x_in;
    filt_cfg_pkg::sample_t y;
    logic y_valid;

    // reference model
    filt_cfg_pkg::sample_t m_taps [filt_cfg_pkg::num_taps];
    filt_cfg_pkg::sample_t m_tbl [filt_cfg_pkg::num_uniq][filt_cfg_pkg::num_levels];
    logic m_enabled;
    int m_miss;
    // expected y and the edge that accepted its sample
    filt_cfg_pkg::sample_t exp_y [$];
    int exp_edge [$];
    filt_cfg_pkg::sample_t exp_v;
    int exp_at;

    int cycle = 0;
    int seed;
    int sva_fails;
    int n_accepted;
    int n_outputs;
    logic [31:0] rd;

    pam_fir_top UUT (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .sample_en(sample_en),
        .x_in     (x_in),
        .apb_rsp  (apb_rsp),
        .y        (y),
        .y_valid  (y_valid)
    );

    always #clk_half sys_clk = ~sys_clk;

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    // run limit
    always @(posedge sys_clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: test still running after %0d cycles", cycle);
            report_failure();
        end
    end

    task automatic compare_sample(input filt_cfg_pkg::sample_t got,
                                  input filt_cfg_pkg::sample_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            report_failure();
        end
    endtask

    // every output checked against the queue at mid cycle
    always @(negedge sys_clk) begin
        if (!reset && y_valid) begin
            n_outputs++;
            if (exp_y.size() == 0) begin
                $display("y_valid pulsed at %0t with no output expected", $time);
                report_failure();
            end else begin
                exp_v = exp_y.pop_front();
                exp_at = exp_edge.pop_front();
                compare_sample(y, exp_v, "y");
                compare_word(cycle - exp_at, filt_cfg_pkg::pipe_latency, "latency");
            end
        end
    end

    // 18-bit clamp
    function automatic filt_cfg_pkg::sample_t clamp_add(input int a, input int b);
        int s;
        s = a + b;
        if (s > sample_hi) begin
            s = sample_hi;
        end else if (s < sample_lo) begin
            s = sample_lo;
        end
        return filt_cfg_pkg::sample_t'(s);
    endfunction

    // level index of a pre-added tap or -1 when nothing matches
    function automatic int match_level(input int k, input int v);
        int lvl;
        int found;
        found = -1;
        if (k < filt_cfg_pkg::num_pairs) begin
            for (int j = 0; j < 7; j++) begin
                lvl = (j - 3) * 32768;
                if (v > lvl - filt_cfg_pkg::level_tol && v < lvl + filt_cfg_pkg::level_tol) begin
                    found = j;
                end
            end
        end else begin
            for (int j = 0; j < 4; j++) begin
                lvl = -49152 + j * 32768;
                if (v > lvl - filt_cfg_pkg::level_tol && v < lvl + filt_cfg_pkg::level_tol) begin
                    found = 7 + j;
                end
            end
        end
        return found;
    endfunction

    task automatic model_accept(input filt_cfg_pkg::sample_t x);
        filt_cfg_pkg::sample_t prod [filt_cfg_pkg::num_uniq];
        filt_cfg_pkg::sample_t l1 [4];
        filt_cfg_pkg::sample_t l2 [2];
        int v;
        int idx;
        logic missed;
        missed = 1'b0;
        for (int i = filt_cfg_pkg::num_taps - 1; i > 0; i--) begin
            m_taps[i] = m_taps[i-1];
        end
        m_taps[0] = x >>> 1;
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            if (k < filt_cfg_pkg::num_pairs) begin
                v = clamp_add(m_taps[k], m_taps[filt_cfg_pkg::num_taps - 1 - k]);
            end else begin
                v = m_taps[k];
            end
            idx = match_level(k, v);
            if (idx < 0) begin
                prod[k] = '0;
                missed = 1'b1;
            end else begin
                prod[k] = m_tbl[k][idx];
            end
        end
        // neighbours first and then pairs of pairs
        for (int i = 0; i < 4; i++) begin
            l1[i] = clamp_add(prod[2*i], prod[2*i+1]);
        end
        l2[0] = clamp_add(l1[0], l1[1]);
        l2[1] = clamp_add(l1[2], l1[3]);
        exp_y.push_back(clamp_add(l2[0], l2[1]));
        exp_edge.push_back(cycle + 1);
        n_accepted++;
        if (missed && m_miss < 32'hffff) begin
            m_miss++;
        end
    endtask

    task automatic clear_model_taps();
        for (int i = 0; i < filt_cfg_pkg::num_taps; i++) begin
            m_taps[i] = '0;
        end
    endtask

    function automatic int rand_range(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    // one of the four pam levels in 1s17
    function automatic filt_cfg_pkg::sample_t rand_symbol();
        int r;
        r = rand_range(4);
        return filt_cfg_pkg::sample_t'((2 * r - 3) * 32768);
    endfunction

    task automatic idle(input int n);
        sample_en = 1'b0;
        repeat (n) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic strobe(input filt_cfg_pkg::sample_t x);
        sample_en = 1'b1;
        x_in = x;
        if (m_enabled) begin
            model_accept(x);
        end
        @(posedge sys_clk);
        #1;
        sample_en = 1'b0;
    endtask

    // last output lands pipe_latency edges after the last accepted strobe
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_y.size() != 0 && waited < filt_cfg_pkg::pipe_latency + 2) begin
            @(posedge sys_clk);
            #1;
            waited++;
        end
        idle(4);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = 1'b1;
        apb_req.paddr = addr;
        apb_req.pwdata = data;
        @(posedge sys_clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge sys_clk);
        compare_word(apb_rsp.pslverr, exp_err, "pslverr on write");
        @(posedge sys_clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = 1'b0;
        apb_req.paddr = addr;
        @(posedge sys_clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge sys_clk);
        data = apb_rsp.prdata;
        compare_word(apb_rsp.pslverr, 0, "pslverr on read");
        @(posedge sys_clk);
        #1;
        apb_req = '0;
    endtask

    function automatic logic [11:0] table_addr(input int tap, input int level);
        return filt_bus_pkg::table_base + 12'((tap * 16 + level) * 4);
    endfunction

    // distinct per entry with the sign of the level
    function automatic filt_cfg_pkg::sample_t table_value(input int tap, input int level,
                                                         input int scale);
        int w;
        if (level < 7) begin
            w = level - 3;
        end else begin
            w = 2 * (level - 7) - 3;
        end
        return filt_cfg_pkg::sample_t'(w * scale + tap * 131 + level * 7);
    endfunction

    task automatic load_table(input int scale);
        filt_cfg_pkg::sample_t v;
        for (int t = 0; t < filt_cfg_pkg::num_uniq; t++) begin
            for (int l = 0; l < filt_cfg_pkg::num_levels; l++) begin
                v = table_value(t, l, scale);
                apb_write(table_addr(t, l), 32'(v), 1'b0);
                m_tbl[t][l] = v;
            end
        end
    endtask

    task automatic set_enable(input logic on);
        apb_write(filt_bus_pkg::reg_ctrl, {31'd0, on}, 1'b0);
        m_enabled = on;
    endtask

    task automatic reset_defaults();
        apb_read(filt_bus_pkg::reg_ctrl, rd);
        compare_word(rd, 0, "reg_ctrl after reset");
        apb_read(filt_bus_pkg::reg_miss, rd);
        compare_word(rd, 0, "reg_miss after reset");
        // enable still off so the monitor flags any output
        repeat (10) strobe(rand_symbol());
        idle(10);
    endtask

    task automatic impulse_response();
        load_table(9000);
        // entry now holds a nonzero product
        apb_read(table_addr(3, 5), rd);
        compare_word(rd, 0, "table read");
        set_enable(1'b1);
        strobe(18'sd98304);
        repeat (filt_cfg_pkg::num_taps) strobe('0);
        strobe(-18'sd32768);
        repeat (filt_cfg_pkg::num_taps) strobe('0);
        drain();
    endtask

    // large products push the tree into saturation
    task automatic random_stream();
        load_table(40000);
        n_accepted = 0;
        n_outputs = 0;
        repeat (stream_half) strobe(rand_symbol());
        repeat (stream_half) begin
            strobe(rand_symbol());
            idle(rand_range(max_gap + 1));
        end
        drain();
        compare_word(n_outputs, n_accepted, "y_valid count");
    endtask

    task automatic off_level_samples();
        filt_cfg_pkg::sample_t s;
        int kind;
        apb_write(filt_bus_pkg::reg_miss, 32'd0, 1'b0);
        m_miss = 0;
        repeat (40) begin
            kind = rand_range(3);
            if (kind == 0) begin
                s = rand_symbol();
            end else if (kind == 1) begin
                // near a level so it lands around the tolerance edge
                s = rand_symbol() + filt_cfg_pkg::sample_t'(rand_range(32) - 16);
            end else begin
                s = rand_symbol() + 18'sd300;
            end
            strobe(s);
        end
        drain();
        apb_read(filt_bus_pkg::reg_miss, rd);
        compare_word(rd, m_miss, "miss count");
        apb_write(filt_bus_pkg::reg_miss, 32'd0, 1'b0);
        m_miss = 0;
        apb_read(filt_bus_pkg::reg_miss, rd);
        compare_word(rd, 0, "miss count after clear");
    endtask

    task automatic flush_and_disable();
        repeat (20) strobe(rand_symbol());
        // flush pulse with enable kept on
        apb_write(filt_bus_pkg::reg_ctrl, 32'h3, 1'b0);
        clear_model_taps();
        idle(1);
        repeat (15) strobe(rand_symbol());
        drain();
        apb_read(filt_bus_pkg::reg_ctrl, rd);
        compare_word(rd, 1, "reg_ctrl after flush");
        set_enable(1'b0);
        repeat (10) strobe(rand_symbol());
        idle(12);
    endtask

    task automatic bad_table_address();
        set_enable(1'b1);
        apb_write(table_addr(2, 11), 32'h1ffff, 1'b1);
        apb_write(table_addr(5, 15), 32'h2aaaa, 1'b1);
        // tap 8 lies past the table
        apb_write(table_addr(8, 3), 32'h15555, 1'b1);
        apb_write(12'h008, 32'h1, 1'b1);
        strobe(-18'sd98304);
        repeat (filt_cfg_pkg::num_taps) strobe(rand_symbol());
        drain();
    endtask

    initial begin
        seed = 32'h7688;
        n_accepted = 0;
        n_outputs = 0;
        reset = 1'b1;
        sample_en = 1'b0;
        x_in = '0;
        apb_req = '0;
        m_enabled = 1'b0;
        m_miss = 0;
        clear_model_taps();
        for (int t = 0; t < filt_cfg_pkg::num_uniq; t++) begin
            for (int l = 0; l < filt_cfg_pkg::num_levels; l++) begin
                m_tbl[t][l] = '0;
            end
        end
        repeat (reset_cycles) @(posedge sys_clk);
        #1;
        reset = 1'b0;

        reset_defaults();
        impulse_response();
        random_stream();
        off_level_samples();
        flush_and_disable();
        bad_table_address();
        idle(4);
        compare_word(exp_y.size(), 0, "outputs never seen");

        sva_fails = UUT.u_sva.n_reset_fail + UUT.u_sva.n_pready_fail
                  + UUT.u_sva.n_slverr_fail;
        if (sva_fails == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/pam_fir_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam_fir_sva (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_bus_pkg::apb_req_t apb_req,
    input  filt_bus_pkg::apb_rsp_t apb_rsp,
    input  wire logic y_valid
);

    // failure tallies, summed by the testbench at the end
    int unsigned n_reset_fail = 0;
    int unsigned n_pready_fail = 0;
    int unsigned n_slverr_fail = 0;

    // output quiet while held in reset
    reset_quiet: assert property (@(posedge sys_clk) reset |=> !y_valid)
        else begin
            $error("y_valid high while reset is asserted");
            n_reset_fail++;
        end

    // zero wait states on every access phase
    pready_high: assert property (@(posedge sys_clk) disable iff (reset)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else begin
            $error("pready low in an access phase");
            n_pready_fail++;
        end

    // error response only with penable up
    slverr_in_access: assert property (@(posedge sys_clk) disable iff (reset)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("pslverr outside an access phase");
            n_slverr_fail++;
        end

endmodule

bind pam_fir_top pam_fir_sva u_sva (
    .sys_clk(sys_clk),
    .reset  (reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .y_valid(y_valid)
);

`default_nettype wire

// ==== hw/pam_fir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam_fir_top (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_bus_pkg::apb_req_t apb_req,
    input  wire logic sample_en,
    input  filt_cfg_pkg::sample_t x_in,
    output filt_bus_pkg::apb_rsp_t apb_rsp,
    output filt_cfg_pkg::sample_t y,
    output logic y_valid
);

    logic shift_en;
    logic flush;
    filt_bus_pkg::table_wr_t table_wr;
    filt_cfg_pkg::pair_sums_t sums;
    filt_cfg_pkg::tap_levels_t levels;
    filt_cfg_pkg::products_t products;

    // host registers and sample gating
    filt_ctrl u_ctrl (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .sample_en (sample_en),
        .shift_en  (shift_en),
        .flush     (flush),
        .table_wr  (table_wr),
        .miss_valid(levels.valid),
        .miss      (levels.miss)
    );

    // taps and pre-add
    sym_delay_line u_delay (
        .sys_clk (sys_clk),
        .reset   (reset),
        .shift_en(shift_en),
        .flush   (flush),
        .x_in    (x_in),
        .sums    (sums)
    );

    level_mapper u_mapper (
        .sys_clk(sys_clk),
        .reset  (reset),
        .sums   (sums),
        .levels (levels)
    );

    // products in place of multipliers
    product_lut u_lut (
        .sys_clk (sys_clk),
        .reset   (reset),
        .table_wr(table_wr),
        .levels  (levels),
        .products(products)
    );

    adder_tree u_tree (
        .sys_clk (sys_clk),
        .reset   (reset),
        .products(products),
        .y       (y),
        .y_valid (y_valid)
    );

endmodule

`default_nettype wire

// ==== hw/adder_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module adder_tree (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_cfg_pkg::products_t products,
    output filt_cfg_pkg::sample_t y,
    output logic y_valid
);

    filt_cfg_pkg::sample_t lvl1 [4];
    filt_cfg_pkg::sample_t lvl2 [2];
    filt_cfg_pkg::sample_t y_q;
    logic v1, v2, v3;

    // level 1, neighbouring products
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < 4; i++) begin
            lvl1[i] <= filt_cfg_pkg::sat_add(products.prod[2*i], products.prod[2*i+1]);
        end
    end

    // level 2
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < 2; i++) begin
            lvl2[i] <= filt_cfg_pkg::sat_add(lvl1[2*i], lvl1[2*i+1]);
        end
    end

    // final sum
    always_ff @(posedge sys_clk) begin
        y_q <= filt_cfg_pkg::sat_add(lvl2[0], lvl2[1]);
    end

    // valid rides alongside the three levels
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= products.valid;
            v2 <= v1;
            v3 <= v2;
        end
    end

    assign y = y_q;
    assign y_valid = v3;

endmodule

`default_nettype wire

// ==== hw/product_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_lut (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_bus_pkg::table_wr_t table_wr,
    input  filt_cfg_pkg::tap_levels_t levels,
    output filt_cfg_pkg::products_t products
);

    // coefficient times level, one row per unique tap
    filt_cfg_pkg::sample_t tbl [filt_cfg_pkg::num_uniq][filt_cfg_pkg::num_levels];
    filt_cfg_pkg::sample_t prod_q [filt_cfg_pkg::num_uniq];
    logic valid_q;

    // table starts out zero
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int t = 0; t < filt_cfg_pkg::num_uniq; t++) begin
                for (int l = 0; l < filt_cfg_pkg::num_levels; l++) begin
                    tbl[t][l] <= '0;
                end
            end
        end else if (table_wr.en) begin
            tbl[table_wr.tap][table_wr.level] <= table_wr.data;
        end
    end

    // lookup per tap, no match gives zero
    always_ff @(posedge sys_clk) begin
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            if (levels.hit[k] && (int'(levels.idx[k]) < filt_cfg_pkg::num_levels)) begin
                prod_q[k] <= tbl[k][levels.idx[k]];
            end else begin
                prod_q[k] <= '0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= levels.valid;
        end
    end

    always_comb begin
        products.valid = valid_q;
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            products.prod[k] = prod_q[k];
        end
    end

endmodule

`default_nettype wire

// ==== hw/level_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_mapper (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_cfg_pkg::pair_sums_t sums,
    output filt_cfg_pkg::tap_levels_t levels
);

    filt_cfg_pkg::level_idx_t idx_c [filt_cfg_pkg::num_uniq];
    logic [filt_cfg_pkg::num_uniq-1:0] hit_c;
    filt_cfg_pkg::level_idx_t idx_q [filt_cfg_pkg::num_uniq];
    logic [filt_cfg_pkg::num_uniq-1:0] hit_q;
    logic miss_q;
    logic valid_q;

    // strictly inside lvl +/- tol
    function automatic logic in_tol(input filt_cfg_pkg::sample_t v,
                                    input filt_cfg_pkg::sample_t lvl);
        return (v > lvl - filt_cfg_pkg::level_tol) && (v < lvl + filt_cfg_pkg::level_tol);
    endfunction

    always_comb begin
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            idx_c[k] = '0;
            hit_c[k] = 1'b0;
        end
        // pair taps against the seven pair sums
        for (int k = 0; k < filt_cfg_pkg::num_pairs; k++) begin
            for (int j = 0; j < filt_cfg_pkg::num_pair_levels; j++) begin
                if (in_tol(sums.sum[k], filt_cfg_pkg::pair_levels[j])) begin
                    idx_c[k] = filt_cfg_pkg::level_idx_t'(j);
                    hit_c[k] = 1'b1;
                end
            end
        end
        // center against its four, index offset past the pair levels
        for (int j = 0; j < filt_cfg_pkg::num_center_levels; j++) begin
            if (in_tol(sums.sum[filt_cfg_pkg::num_pairs], filt_cfg_pkg::center_levels[j])) begin
                idx_c[filt_cfg_pkg::num_pairs] =
                    filt_cfg_pkg::level_idx_t'(filt_cfg_pkg::num_pair_levels + j);
                hit_c[filt_cfg_pkg::num_pairs] = 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sums.valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        idx_q <= idx_c;
        hit_q <= hit_c;
        // any tap without a level
        miss_q <= !(&hit_c);
    end

    always_comb begin
        levels.valid = valid_q;
        levels.hit = hit_q;
        levels.miss = miss_q;
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            levels.idx[k] = idx_q[k];
        end
    end

endmodule

`default_nettype wire

// ==== hw/sym_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module sym_delay_line (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  wire logic shift_en,
    input  wire logic flush,
    input  filt_cfg_pkg::sample_t x_in,
    output filt_cfg_pkg::pair_sums_t sums
);

    filt_cfg_pkg::sample_t taps [filt_cfg_pkg::num_taps];
    filt_cfg_pkg::sample_t sum_q [filt_cfg_pkg::num_uniq];
    logic shift_d;
    logic valid_q;

    // shift register, 1s17 halved to 2s16 on entry
    always_ff @(posedge sys_clk) begin
        if (reset || flush) begin
            for (int i = 0; i < filt_cfg_pkg::num_taps; i++) begin
                taps[i] <= '0;
            end
        end else if (shift_en) begin
            taps[0] <= x_in >>> 1;
            for (int i = 1; i < filt_cfg_pkg::num_taps; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // valid follows the shift by one cycle, a flushed strobe is dropped
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            shift_d <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            shift_d <= shift_en && !flush;
            valid_q <= shift_d;
        end
    end

    // mirrored pre-add, tap k with tap 14-k
    always_ff @(posedge sys_clk) begin
        for (int k = 0; k < filt_cfg_pkg::num_pairs; k++) begin
            sum_q[k] <= filt_cfg_pkg::sat_add(taps[k], taps[filt_cfg_pkg::num_taps-1-k]);
        end
        // center tap passes alone
        sum_q[filt_cfg_pkg::num_pairs] <= taps[filt_cfg_pkg::num_pairs];
    end

    always_comb begin
        sums.valid = valid_q;
        for (int k = 0; k < filt_cfg_pkg::num_uniq; k++) begin
            sums.sum[k] = sum_q[k];
        end
    end

endmodule

`default_nettype wire

// ==== hw/filt_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module filt_ctrl (
    input  wire logic sys_clk,
    input  wire logic reset,
    input  filt_bus_pkg::apb_req_t apb_req,
    output filt_bus_pkg::apb_rsp_t apb_rsp,
    input  wire logic sample_en,
    output logic shift_en,
    output logic flush,
    output filt_bus_pkg::table_wr_t table_wr,
    input  wire logic miss_valid,
    input  wire logic miss
);

    logic enable_q;
    logic flush_q;
    logic [15:0] miss_cnt;

    logic access, wr_acc;
    logic is_ctrl, is_miss, in_table, level_ok, mapped;
    logic [11:0] tbl_off;
    logic [31:0] rdata;

    // access phase of any transfer
    assign access = apb_req.psel && apb_req.penable;
    assign wr_acc = access && apb_req.pwrite;

    // address decode
    assign is_ctrl = (apb_req.paddr == filt_bus_pkg::reg_ctrl);
    assign is_miss = (apb_req.paddr == filt_bus_pkg::reg_miss);
    assign tbl_off = apb_req.paddr - filt_bus_pkg::table_base;
    assign in_table = (apb_req.paddr >= filt_bus_pkg::table_base)
                   && (tbl_off < filt_bus_pkg::table_span)
                   && (apb_req.paddr[1:0] == 2'b00);
    // tap lives in off[8:6], level in off[5:2]
    assign level_ok = (int'(tbl_off[5:2]) < filt_cfg_pkg::num_levels);
    assign mapped = is_ctrl || is_miss || (in_table && level_ok);

    // enable and self-clearing flush
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            enable_q <= 1'b0;
            flush_q <= 1'b0;
        end else if (wr_acc && is_ctrl) begin
            enable_q <= apb_req.pwdata[filt_bus_pkg::ctrl_enable_bit];
            flush_q <= apb_req.pwdata[filt_bus_pkg::ctrl_flush_bit];
        end else begin
            flush_q <= 1'b0;
        end
    end

    // miss count, a write clears it, saturates at all ones
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            miss_cnt <= '0;
        end else if (wr_acc && is_miss) begin
            miss_cnt <= '0;
        end else if (miss_valid && miss && (miss_cnt != 16'hffff)) begin
            miss_cnt <= miss_cnt + 16'd1;
        end
    end

    // read mux, table reads give zero
    always_comb begin
        rdata = '0;
        if (is_ctrl) begin
            rdata[filt_bus_pkg::ctrl_enable_bit] = enable_q;
            rdata[filt_bus_pkg::ctrl_flush_bit] = flush_q;
        end else if (is_miss) begin
            rdata[15:0] = miss_cnt;
        end
    end

    assign apb_rsp.prdata = rdata;
    // zero wait states
    assign apb_rsp.pready = 1'b1;
    assign apb_rsp.pslverr = access && !mapped;

    // table write goes out during the access cycle
    assign table_wr.en = wr_acc && in_table && level_ok;
    assign table_wr.tap = tbl_off[8:6];
    assign table_wr.level = tbl_off[5:2];
    assign table_wr.data = filt_cfg_pkg::sample_t'(apb_req.pwdata[17:0]);

    // samples only pass while enabled
    assign shift_en = sample_en && enable_q;
    assign flush = flush_q;

endmodule

`default_nettype wire

// ==== hw/filt_bus_pkg.sv ====
`default_nettype none

package filt_bus_pkg;

    // host side of the apb link
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // one product table entry write
    typedef struct packed {
        logic en;
        logic [2:0] tap;
        logic [3:0] level;
        filt_cfg_pkg::sample_t data;
    } table_wr_t;

    // register map
    localparam logic [11:0] reg_ctrl = 12'h000;
    localparam logic [11:0] reg_miss = 12'h004;
    // table entry at table_base + (tap*16 + level)*4
    localparam logic [11:0] table_base = 12'h100;
    localparam logic [11:0] table_span = 12'h200;

    // control register bits
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_flush_bit = 1;

endpackage

`default_nettype wire

// ==== hw/filt_cfg_pkg.sv ====
`default_nettype none

package filt_cfg_pkg;

    // sample format, 1s17 at the input and 2s16 inside the filter
    localparam int sample_w = 18;
    typedef logic signed [sample_w-1:0] sample_t;

    localparam sample_t sample_max = sample_t'(2 ** (sample_w - 1) - 1);
    localparam sample_t sample_min = sample_t'(-(2 ** (sample_w - 1)));

    // filter geometry
    localparam int num_taps = 15;
    localparam int num_pairs = 7;
    localparam int num_uniq = 8;

    // symbol levels after the pre-add, lowest first
    localparam int num_pair_levels = 7;
    localparam int num_center_levels = 4;
    localparam int num_levels = num_pair_levels + num_center_levels;
    localparam sample_t pair_levels [num_pair_levels] = '{
        -18'sd98304, -18'sd65536, -18'sd32768, 18'sd0,
        18'sd32768, 18'sd65536, 18'sd98304
    };
    // center tap levels sit at indices 7..10
    localparam sample_t center_levels [num_center_levels] = '{
        -18'sd49152, -18'sd16384, 18'sd16384, 18'sd49152
    };
    localparam int level_tol = 10;

    typedef logic [3:0] level_idx_t;

    // sample edge to y_valid edge
    localparam int pipe_latency = 6;

    // entry 7 is the center tap
    typedef struct packed {
        logic valid;
        sample_t [num_uniq-1:0] sum;
    } pair_sums_t;

    typedef struct packed {
        logic valid;
        level_idx_t [num_uniq-1:0] idx;
        logic [num_uniq-1:0] hit;
        logic miss;
    } tap_levels_t;

    typedef struct packed {
        logic valid;
        sample_t [num_uniq-1:0] prod;
    } products_t;

    // add with clamp to the 18-bit signed range
    function automatic sample_t sat_add(input sample_t a, input sample_t b);
        logic signed [sample_w:0] s;
        s = a + b;
        if (s[sample_w] != s[sample_w-1]) begin
            return s[sample_w] ? sample_min : sample_max;
        end
        return s[sample_w-1:0];
    endfunction

endpackage

`default_nettype wire
